// File: src.f
src/mem_pkg.sv
src/avalon_ddr3_interface.sv
src/copy_engine.sv
src/copy_regs.sv
src/avalon_ram.sv
src/copy_top.sv
testbench/copy_top_tb.sv

// File: src/avalon_ddr3_interface.sv
// Single-beat Avalon-MM master
// Runs one read or one write per request and pulses a completion strobe
`timescale 1ns/1ps
`default_nettype none

module avalon_ddr3_interface (
    input  logic                       main_clk,
    input  logic                       main_reset,
    input  logic                       rd_en,
    input  logic                       wr_en,
    input  logic [mem_pkg::ADDR_W-1:0] sdram_address,
    input  logic [mem_pkg::DATA_W-1:0] write_data_input,
    output logic [mem_pkg::DATA_W-1:0] read_data,
    output logic                       read_complete,
    output logic                       write_complete,
    output mem_pkg::avm_req_t          avm_req,
    input  mem_pkg::avm_rsp_t          avm_rsp
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ_REQ,
        ST_READ_WAIT
    } state_t;

    state_t state;
    state_t state_next;

    // Request captured when the enable is sampled
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // Write wins when both enables are high
                if (wr_en) begin
                    state_next = ST_WRITE;
                end else if (rd_en) begin
                    state_next = ST_READ_REQ;
                end
            end
            ST_WRITE: begin
                if (!avm_rsp.waitrequest) begin
                    state_next = ST_IDLE;
                end
            end
            ST_READ_REQ: begin
                // Accepted read, now wait for the data beat
                if (!avm_rsp.waitrequest) begin
                    state_next = ST_READ_WAIT;
                end
            end
            ST_READ_WAIT: begin
                if (avm_rsp.readdatavalid) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge main_clk) begin
        if (main_reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge main_clk) begin
        if (state == ST_IDLE && (wr_en || rd_en)) begin
            addr_q <= sdram_address;
            data_q <= write_data_input;
        end
        // Read data lands one cycle after read_complete
        if (state == ST_READ_WAIT && avm_rsp.readdatavalid) begin
            read_data <= avm_rsp.readdata;
        end
    end

    // Held request fields keep the bus stable under waitrequest
    always_comb begin
        avm_req.read      = (state == ST_READ_REQ);
        avm_req.write     = (state == ST_WRITE);
        avm_req.address   = addr_q;
        avm_req.writedata = data_q;
    end

    assign write_complete = (state == ST_WRITE) && !avm_rsp.waitrequest;
    assign read_complete  = (state == ST_READ_WAIT) && avm_rsp.readdatavalid;

    // Requests from the engine only arrive while the master is idle
    a_req_idle: assert property (@(posedge main_clk) disable iff (main_reset)
        (rd_en || wr_en) |-> state == ST_IDLE);

    // Slave back-pressure must not see the request move
    a_req_stable: assert property (@(posedge main_clk) disable iff (main_reset)
        (avm_req.read || avm_req.write) && avm_rsp.waitrequest |=> $stable(avm_req));

endmodule

`default_nettype wire

// File: src/avalon_ram.sv
// On-chip RAM Avalon-MM slave
// Stands in for the DDR controller with fixed wait states and fixed read latency
`timescale 1ns/1ps
`default_nettype none

module avalon_ram (
    input  logic              main_clk,
    input  logic              main_reset,
    input  mem_pkg::avm_req_t avm_req,
    output mem_pkg::avm_rsp_t avm_rsp
);
    import mem_pkg::*;

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    // Wait states spent on the current request
    logic [RAM_WAIT_W-1:0] wait_cnt;

    // Read latency pipeline, last stage faces the bus
    logic [RAM_READ_LATENCY-1:0] valid_pipe;
    logic [DATA_W-1:0] data_pipe [RAM_READ_LATENCY];

    logic req_valid;
    logic accept;
    logic [RAM_IDX_W-1:0] word_idx;

    assign req_valid = avm_req.read || avm_req.write;
    assign accept    = req_valid && !avm_rsp.waitrequest;
    // Only the low address bits decode
    assign word_idx  = avm_req.address[RAM_IDX_W-1:0];

    always_comb begin
        avm_rsp.waitrequest   = req_valid && (wait_cnt != RAM_WAIT_W'(RAM_WAIT_CYCLES));
        avm_rsp.readdatavalid = valid_pipe[RAM_READ_LATENCY-1];
        avm_rsp.readdata      = data_pipe[RAM_READ_LATENCY-1];
    end

    always_ff @(posedge main_clk) begin
        if (main_reset) begin
            wait_cnt <= '0;
        end else if (accept) begin
            wait_cnt <= '0;
        end else if (req_valid) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // One valid bit enters per accepted read
    always_ff @(posedge main_clk) begin
        if (main_reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= (valid_pipe << 1) | RAM_READ_LATENCY'(accept && avm_req.read);
        end
    end

    always_ff @(posedge main_clk) begin
        if (accept && avm_req.write) begin
            mem[word_idx] <= avm_req.writedata;
        end
        // Data stages shift freely, valid_pipe marks the real beats
        data_pipe[0] <= mem[word_idx];
        for (int i = 1; i < RAM_READ_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    a_no_rd_wr: assert property (@(posedge main_clk) disable iff (main_reset)
        !(avm_req.read && avm_req.write));

endmodule

`default_nettype wire

// File: src/copy_engine.sv
// Copy and check sequencer
// Turns a FILL, COPY or SUM command into single-word transfers and folds the checksum
`timescale 1ns/1ps
`default_nettype none

module copy_engine (
    input  logic                       main_clk,
    input  logic                       main_reset,
    input  mem_pkg::copy_cmd_t         cmd,
    input  logic                       start,
    output logic                       busy,
    output logic                       done,
    output logic [31:0]                result,
    output logic                       rd_en,
    output logic                       wr_en,
    output logic [mem_pkg::ADDR_W-1:0] sdram_address,
    output logic [mem_pkg::DATA_W-1:0] write_data_input,
    input  logic [mem_pkg::DATA_W-1:0] read_data,
    input  logic                       read_complete,
    input  logic                       write_complete
);
    import mem_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_RD,
        ST_RD_DATA,
        ST_WAIT_WR
    } state_t;

    state_t state;
    copy_cmd_t cmd_q;
    logic [15:0] idx;
    logic [ADDR_W-1:0] idx_ext;
    logic [DATA_W-1:0] fill_word;
    logic [LANE_W-1:0] lane_sum;

    assign idx_ext = ADDR_W'(idx);
    assign busy    = (state != ST_IDLE);

    // Fill pattern for word idx and lane sum of the returned word
    always_comb begin
        fill_word = '0;
        lane_sum  = '0;
        for (int k = 0; k < LANES; k++) begin
            fill_word[k*LANE_W +: LANE_W] = cmd_q.seed + LANE_W'(idx) * LANE_W'(LANES)
                                            + LANE_W'(k);
            lane_sum = lane_sum + read_data[k*LANE_W +: LANE_W];
        end
    end

    // One-cycle requests to the master, only issued while it is idle
    always_comb begin
        rd_en            = 1'b0;
        wr_en            = 1'b0;
        sdram_address    = cmd_q.dst + idx_ext;
        write_data_input = fill_word;
        if (state == ST_ISSUE && idx != cmd_q.count) begin
            if (cmd_q.op == OP_FILL) begin
                wr_en = 1'b1;
            end else begin
                rd_en         = 1'b1;
                sdram_address = cmd_q.src + idx_ext;
            end
        end
        // COPY writes back the word straight out of the master
        if (state == ST_RD_DATA && cmd_q.op == OP_COPY) begin
            wr_en            = 1'b1;
            write_data_input = read_data;
        end
    end

    always_ff @(posedge main_clk) begin
        if (state == ST_IDLE && start) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge main_clk) begin
        if (main_reset) begin
            state  <= ST_IDLE;
            idx    <= '0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Start while busy never reaches here
                    if (start) begin
                        state <= ST_ISSUE;
                        idx   <= '0;
                        if (cmd.op == OP_SUM) begin
                            result <= '0;
                        end
                    end
                end
                ST_ISSUE: begin
                    if (idx == cmd_q.count) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end else if (cmd_q.op == OP_FILL) begin
                        state <= ST_WAIT_WR;
                    end else begin
                        state <= ST_WAIT_RD;
                    end
                end
                ST_WAIT_RD: begin
                    if (read_complete) begin
                        state <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (cmd_q.op == OP_COPY) begin
                        state <= ST_WAIT_WR;
                    end else begin
                        result <= result + lane_sum;
                        idx    <= idx + 16'd1;
                        state  <= ST_ISSUE;
                    end
                end
                ST_WAIT_WR: begin
                    if (write_complete) begin
                        idx   <= idx + 16'd1;
                        state <= ST_ISSUE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Completion strobes only come back for the request in flight
    a_rd_cmpl_expected: assert property (@(posedge main_clk) disable iff (main_reset)
        read_complete |-> state == ST_WAIT_RD);

    a_wr_cmpl_expected: assert property (@(posedge main_clk) disable iff (main_reset)
        write_complete |-> state == ST_WAIT_WR);

endmodule

`default_nettype wire

// File: src/copy_regs.sv
// Software register block
// Holds the command fields, issues the start pulse and reports status and result
`timescale 1ns/1ps
`default_nettype none

module copy_regs (
    input  logic                           main_clk,
    input  logic                           main_reset,
    input  logic                           reg_write,
    input  logic [mem_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [31:0]                    reg_wdata,
    output logic [31:0]                    reg_rdata,
    output mem_pkg::copy_cmd_t             cmd,
    output logic                           start,
    input  logic                           busy,
    input  logic                           done,
    input  logic [31:0]                    result
);
    import mem_pkg::*;

    // Sticky until the next start
    logic done_q;

    always_ff @(posedge main_clk) begin
        if (main_reset) begin
            cmd    <= '0;
            start  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            start <= 1'b0;
            if (reg_write) begin
                case (reg_addr)
                    REG_CTRL: begin
                        cmd.op <= op_t'(reg_wdata[1:0]);
                        start  <= reg_wdata[4];
                    end
                    REG_SRC:   cmd.src   <= reg_wdata;
                    REG_DST:   cmd.dst   <= reg_wdata;
                    REG_COUNT: cmd.count <= reg_wdata[15:0];
                    REG_SEED:  cmd.seed  <= reg_wdata;
                    default: ;
                endcase
            end
            if (start) begin
                done_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1;
            end
        end
    end

    // CTRL is write-only and reads as zero
    always_comb begin
        case (reg_addr)
            REG_SRC:    reg_rdata = cmd.src;
            REG_DST:    reg_rdata = cmd.dst;
            REG_COUNT:  reg_rdata = {16'd0, cmd.count};
            REG_SEED:   reg_rdata = cmd.seed;
            REG_STATUS: reg_rdata = {30'd0, done_q, busy};
            REG_RESULT: reg_rdata = result;
            default:    reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/copy_top.sv
// Memory copy and check subsystem
// Register block, engine, Avalon master and on-chip RAM behind one register port
`timescale 1ns/1ps
`default_nettype none

module copy_top (
    input  logic                           main_clk,
    input  logic                           main_reset,
    input  logic                           reg_write,
    input  logic [mem_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [31:0]                    reg_wdata,
    output logic [31:0]                    reg_rdata
);
    import mem_pkg::*;

    // Register block to engine
    copy_cmd_t   cmd;
    logic        start;
    logic        busy;
    logic        done;
    logic [31:0] result;

    // Engine to master
    logic              rd_en;
    logic              wr_en;
    logic [ADDR_W-1:0] sdram_address;
    logic [DATA_W-1:0] write_data_input;
    logic [DATA_W-1:0] read_data;
    logic              read_complete;
    logic              write_complete;

    // Master to RAM
    avm_req_t avm_req;
    avm_rsp_t avm_rsp;

    copy_regs u_regs (
        .main_clk   (main_clk),
        .main_reset (main_reset),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .cmd        (cmd),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    copy_engine u_engine (
        .main_clk         (main_clk),
        .main_reset       (main_reset),
        .cmd              (cmd),
        .start            (start),
        .busy             (busy),
        .done             (done),
        .result           (result),
        .rd_en            (rd_en),
        .wr_en            (wr_en),
        .sdram_address    (sdram_address),
        .write_data_input (write_data_input),
        .read_data        (read_data),
        .read_complete    (read_complete),
        .write_complete   (write_complete)
    );

    avalon_ddr3_interface u_master (
        .main_clk         (main_clk),
        .main_reset       (main_reset),
        .rd_en            (rd_en),
        .wr_en            (wr_en),
        .sdram_address    (sdram_address),
        .write_data_input (write_data_input),
        .read_data        (read_data),
        .read_complete    (read_complete),
        .write_complete   (write_complete),
        .avm_req          (avm_req),
        .avm_rsp          (avm_rsp)
    );

    avalon_ram u_ram (
        .main_clk   (main_clk),
        .main_reset (main_reset),
        .avm_req    (avm_req),
        .avm_rsp    (avm_rsp)
    );

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
// Shared definitions for the memory copy and check engine
// Bus widths, RAM timing, register map, opcodes and the bus and command structs
`default_nettype none

package mem_pkg;

    // Memory word and Avalon word address
    localparam int DATA_W = 128;
    localparam int ADDR_W = 32;

    // A word splits into 32-bit lanes for fill and checksum
    localparam int LANE_W = 32;
    localparam int LANES  = DATA_W / LANE_W;

    // On-chip RAM geometry and timing
    localparam int RAM_DEPTH        = 64;
    localparam int RAM_IDX_W        = $clog2(RAM_DEPTH);
    localparam int RAM_WAIT_CYCLES  = 2;
    localparam int RAM_WAIT_W       = $clog2(RAM_WAIT_CYCLES + 1);
    localparam int RAM_READ_LATENCY = 2;

    // Register port and register map
    localparam int REG_ADDR_W = 3;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd0;
    localparam logic [REG_ADDR_W-1:0] REG_SRC    = 3'd1;
    localparam logic [REG_ADDR_W-1:0] REG_DST    = 3'd2;
    localparam logic [REG_ADDR_W-1:0] REG_COUNT  = 3'd3;
    localparam logic [REG_ADDR_W-1:0] REG_SEED   = 3'd4;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd5;
    localparam logic [REG_ADDR_W-1:0] REG_RESULT = 3'd6;

    typedef enum logic [1:0] {
        OP_FILL = 2'd0,
        OP_COPY = 2'd1,
        OP_SUM  = 2'd2
    } op_t;

    // Master to slave
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] writedata;
    } avm_req_t;

    // Slave to master
    typedef struct packed {
        logic [DATA_W-1:0] readdata;
        logic              readdatavalid;
        logic              waitrequest;
    } avm_rsp_t;

    // One operation as software sets it up
    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [15:0]       count;
        logic [31:0]       seed;
    } copy_cmd_t;

endpackage

`default_nettype wire

// File: testbench/copy_top_tb.sv
// Testbench for the memory copy and check subsystem
// Table of FILL, COPY and SUM operations checked against a shadow memory model
`timescale 1ns/1ps
`default_nettype none

module copy_top_tb;
    import mem_pkg::*;

    // Upper bound on STATUS polls per wait
    localparam int POLL_LIMIT = 3000;
    localparam int NUM_ROWS   = 13;

    // One table row, the expected RESULT is filled in by the model
    typedef struct packed {
        op_t         op;
        logic [31:0] src;
        logic [31:0] dst;
        logic [15:0] count;
        logic [31:0] seed;
        logic [31:0] exp_result;
    } row_t;

    logic                  main_clk;
    logic                  main_reset;
    logic                  reg_write;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [31:0]           reg_wdata;
    logic [31:0]           reg_rdata;

    row_t stim_rows [NUM_ROWS];

    // Shadow of the RAM contents and of the RESULT register
    logic [DATA_W-1:0] shadow [RAM_DEPTH];
    logic [31:0]       last_sum;

    copy_top DUT (
        .main_clk   (main_clk),
        .main_reset (main_reset),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata)
    );

    always #5 main_clk = ~main_clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, actual,
                     expected);
            $display("TEST FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // One write strobe, sampled by the DUT on the following edge
    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge main_clk);
        reg_write <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge main_clk);
        reg_write <= 1'b0;
    endtask

    // reg_rdata is combinational, so sample it half a cycle later
    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge main_clk);
        reg_addr <= addr;
        @(negedge main_clk);
        data = reg_rdata;
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (status[1] !== 1'b1) begin
            if (polls == POLL_LIMIT) begin
                $display("Timeout at %0t ns: done never showed in STATUS", $time);
                $display("TEST FAILED");
                $fatal(1, "wait for done timed out");
            end
            read_reg(REG_STATUS, status);
            polls++;
        end
    endtask

    task automatic wait_for_busy();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (status[0] !== 1'b1) begin
            if (polls == POLL_LIMIT) begin
                $display("Timeout at %0t ns: busy never showed in STATUS", $time);
                $display("TEST FAILED");
                $fatal(1, "wait for busy timed out");
            end
            read_reg(REG_STATUS, status);
            polls++;
        end
    endtask

    // Program all fields, then CTRL with the start bit
    task automatic run_op(input row_t r);
        write_reg(REG_SRC, r.src);
        write_reg(REG_DST, r.dst);
        write_reg(REG_COUNT, {16'd0, r.count});
        write_reg(REG_SEED, r.seed);
        write_reg(REG_CTRL, 32'h10 | {30'd0, r.op});
    endtask

    // Reference model, applies one operation to the shadow memory
    task automatic model_apply(input row_t r, output logic [31:0] res);
        logic [31:0]       addr;
        logic [31:0]       src_addr;
        logic [DATA_W-1:0] word;
        logic [31:0]       acc;
        acc = '0;
        for (int i = 0; i < r.count; i++) begin
            addr     = r.dst + 32'(i);
            src_addr = r.src + 32'(i);
            case (r.op)
                OP_FILL: begin
                    // Lane k of word i holds seed + 4i + k
                    for (int k = 0; k < 4; k++) begin
                        word[k*32 +: 32] = r.seed + 32'(4 * i + k);
                    end
                    shadow[addr % RAM_DEPTH] = word;
                end
                // Ascending order matters for overlapping regions
                OP_COPY: shadow[addr % RAM_DEPTH] = shadow[src_addr % RAM_DEPTH];
                default: begin
                    word = shadow[src_addr % RAM_DEPTH];
                    for (int k = 0; k < 4; k++) begin
                        acc = acc + word[k*32 +: 32];
                    end
                end
            endcase
        end
        // RESULT only changes on a SUM
        if (r.op == OP_SUM) begin
            last_sum = acc;
        end
        res = last_sum;
    endtask

    function automatic row_t make_row(input op_t op, input logic [31:0] src,
                                      input logic [31:0] dst, input logic [15:0] count,
                                      input logic [31:0] seed);
        row_t r;
        r.op         = op;
        r.src        = src;
        r.dst        = dst;
        r.count      = count;
        r.seed       = seed;
        r.exp_result = '0;
        return r;
    endfunction

    initial begin
        logic [31:0] v;
        logic [31:0] wr_vals [4];
        logic [31:0] busy_sum;
        row_t        sum_row;

        main_clk   = 1'b0;
        main_reset = 1'b1;
        reg_write  = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        last_sum   = '0;
        void'($urandom(32'h28d15940));

        // FILL, SUM, COPY, refill, zero counts, aliased and overlapping regions
        stim_rows[0]  = make_row(OP_FILL, 32'd0, 32'd0, 16'd8, $urandom());
        stim_rows[1]  = make_row(OP_SUM, 32'd0, 32'd0, 16'd8, 32'd0);
        stim_rows[2]  = make_row(OP_COPY, 32'd0, 32'd16, 16'd8, 32'd0);
        stim_rows[3]  = make_row(OP_SUM, 32'd16, 32'd0, 16'd8, 32'd0);
        stim_rows[4]  = make_row(OP_FILL, 32'd0, 32'd0, 16'd8, $urandom());
        stim_rows[5]  = make_row(OP_SUM, 32'd16, 32'd0, 16'd8, 32'd0);
        stim_rows[6]  = make_row(OP_SUM, 32'd0, 32'd0, 16'd8, 32'd0);
        stim_rows[7]  = make_row(OP_SUM, 32'd0, 32'd0, 16'd0, 32'd0);
        stim_rows[8]  = make_row(OP_FILL, 32'd0, 32'd16, 16'd0, $urandom());
        stim_rows[9]  = make_row(OP_SUM, 32'd16, 32'd0, 16'd8, 32'd0);
        stim_rows[10] = make_row(OP_FILL, 32'd0, 32'habcd_0020, 16'd12, $urandom());
        stim_rows[11] = make_row(OP_COPY, 32'd32, 32'd36, 16'd8, 32'd0);
        stim_rows[12] = make_row(OP_SUM, 32'd32, 32'd0, 16'd12, 32'd0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            model_apply(stim_rows[r], stim_rows[r].exp_result);
        end

        repeat (3) @(posedge main_clk);
        main_reset <= 1'b0;

        // Idle state after reset and register readback
        read_reg(REG_STATUS, v);
        check_value(v, 32'd0, "STATUS after reset");
        read_reg(REG_RESULT, v);
        check_value(v, 32'd0, "RESULT after reset");
        for (int i = 0; i < 4; i++) begin
            wr_vals[i] = $urandom();
            write_reg(REG_ADDR_W'(REG_SRC + i), wr_vals[i]);
        end
        read_reg(REG_SRC, v);
        check_value(v, wr_vals[0], "SRC readback");
        read_reg(REG_DST, v);
        check_value(v, wr_vals[1], "DST readback");
        read_reg(REG_COUNT, v);
        check_value(v, {16'd0, wr_vals[2][15:0]}, "COUNT readback");
        read_reg(REG_SEED, v);
        check_value(v, wr_vals[3], "SEED readback");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_op(stim_rows[r]);
            wait_for_done();
            read_reg(REG_STATUS, v);
            check_value(v, 32'd2, $sformatf("row %0d STATUS", r));
            read_reg(REG_RESULT, v);
            check_value(v, stim_rows[r].exp_result, $sformatf("row %0d RESULT", r));
        end

        // Second start during a SUM must be dropped, FILL must not run
        sum_row = make_row(OP_SUM, 32'd0, 32'd0, 16'd8, 32'd0);
        model_apply(sum_row, busy_sum);
        run_op(sum_row);
        wait_for_busy();
        write_reg(REG_CTRL, 32'h10 | {30'd0, OP_FILL});
        wait_for_done();
        read_reg(REG_RESULT, v);
        check_value(v, busy_sum, "RESULT with start while busy");
        run_op(sum_row);
        wait_for_done();
        read_reg(REG_RESULT, v);
        check_value(v, busy_sum, "region after ignored start");

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
